//--- Makefile
.PHONY: all build lint clean

all: build
	./obj_dir/Vtb_top +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	! grep -q "TEST RESULT: FAIL" sim.log
	grep -q "TEST RESULT: PASS" sim.log

build:
	verilator --binary --timing --assert -j 0 --top-module tb_top -f verilog.f

lint:
	verilator --lint-only --timing --assert -Wall --top-module tb_top -f verilog.f

clean:
	rm -rf obj_dir sim.log

//--- common/cache_proto_pkg.sv
package cache_proto_pkg;

  // ------------------------------
  // cache geometry
  // ------------------------------
  // the pseudo-LRU tree is 3 bits, so the way count stays at 4
  localparam int NUM_WAYS = 4;
  localparam int WAY_W    = 2;

  // ------------------------------
  // channel encodings
  // ------------------------------
  // core request opcodes
  typedef enum logic [1:0] {
    CORE_RD  = 2'd0,
    CORE_RFO = 2'd1,
    CORE_WB  = 2'd2
  } core_op_t;

  // memory request opcodes
  typedef enum logic [1:0] {
    MEM_RD  = 2'd0,
    MEM_RFO = 2'd1,
    MEM_WB  = 2'd2
  } mem_op_t;

  // core response codes
  typedef enum logic {
    RSP_OKAY  = 1'b0,
    RSP_ERROR = 1'b1
  } core_rsp_t;

endpackage

//--- common/cache_state_pkg.sv
package cache_state_pkg;

  // ------------------------------
  // block state
  // ------------------------------
  typedef enum logic [1:0] {
    INVALID   = 2'd0,
    EXCLUSIVE = 2'd1,
    MODIFIED  = 2'd2
  } blk_state_t;

  // ------------------------------
  // controller phases
  // ------------------------------
  // one core request in flight, walked through these in order
  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    LOOKUP     = 3'd1,
    EVICT_REQ  = 3'd2,
    EVICT_WAIT = 3'd3,
    FILL_REQ   = 3'd4,
    FILL_WAIT  = 3'd5,
    SEND_RSP   = 3'd6
  } ctrl_phase_t;

endpackage

//--- hw/cache_array/data_array.sv
`timescale 1ns/100ps

module data_array import cache_proto_pkg::*; #(
  parameter int BLK_W    = 64,
  parameter int NUM_SETS = 4,
  localparam int IDX_W   = $clog2(NUM_SETS)
) (
  input  logic             clk,
  input  logic [IDX_W-1:0] set_idx,
  input  logic [WAY_W-1:0] rd_way,
  input  logic             data_wr_en,
  input  logic [WAY_W-1:0] data_wr_way,
  input  logic [BLK_W-1:0] data_wr_data,
  output logic [BLK_W-1:0] rd_data
);

  // one block per set and way
  logic [BLK_W-1:0] blk_q [NUM_SETS][NUM_WAYS];

  // ------------------------------
  // write port
  // ------------------------------
  always_ff @(posedge clk) begin
    if (data_wr_en) begin
      blk_q[set_idx][data_wr_way] <= data_wr_data;
    end
  end

  // ------------------------------
  // read port
  // ------------------------------
  // combinational, old data until the write edge
  assign rd_data = blk_q[set_idx][rd_way];

endmodule

//--- hw/cache_array/tag_array.sv
`timescale 1ns/100ps

module tag_array import cache_proto_pkg::*; import cache_state_pkg::*; #(
  parameter int ADDR_W   = 6,
  parameter int NUM_SETS = 4,
  localparam int IDX_W   = $clog2(NUM_SETS),
  localparam int TAG_W   = ADDR_W - IDX_W
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [IDX_W-1:0]               set_idx,
  input  logic [TAG_W-1:0]               lookup_tag,
  input  logic                           tag_wr_en,
  input  logic [WAY_W-1:0]               tag_wr_way,
  input  blk_state_t                     tag_wr_state,
  output logic                           lookup_hit,
  output logic [WAY_W-1:0]               hit_way,
  output logic                           free_valid,
  output logic [WAY_W-1:0]               free_way,
  output blk_state_t [NUM_WAYS-1:0]      way_state,
  output logic [NUM_WAYS-1:0][TAG_W-1:0] way_tag
);

  blk_state_t       state_q [NUM_SETS][NUM_WAYS];
  logic [TAG_W-1:0] tag_q   [NUM_SETS][NUM_WAYS];

  // ------------------------------
  // storage
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
          state_q[s][w] <= INVALID;
        end
      end
    end else if (tag_wr_en) begin
      state_q[set_idx][tag_wr_way] <= tag_wr_state;
    end
  end

  always_ff @(posedge clk) begin
    if (tag_wr_en) begin
      tag_q[set_idx][tag_wr_way] <= lookup_tag;
    end
  end

  // ------------------------------
  // lookup
  // ------------------------------
  // walk from the top way down so the lowest free way wins
  always_comb begin
    lookup_hit = 1'b0;
    hit_way    = '0;
    free_valid = 1'b0;
    free_way   = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      way_state[w] = state_q[set_idx][w];
      way_tag[w]   = tag_q[set_idx][w];
      if (state_q[set_idx][w] == INVALID) begin
        free_valid = 1'b1;
        free_way   = WAY_W'(w);
      end else if (tag_q[set_idx][w] == lookup_tag) begin
        lookup_hit = 1'b1;
        hit_way    = WAY_W'(w);
      end
    end
  end

endmodule

//--- hw/cache_ctrl.sv
`timescale 1ns/100ps

module cache_ctrl import cache_proto_pkg::*; import cache_state_pkg::*; #(
  parameter int ADDR_W   = 6,
  parameter int BLK_W    = 64,
  parameter int NUM_SETS = 4,
  localparam int IDX_W   = $clog2(NUM_SETS),
  localparam int TAG_W   = ADDR_W - IDX_W
) (
  input  logic                           clk,
  input  logic                           rst_n,

  // core request / response
  input  logic                           cdreq_valid,
  input  core_op_t                       cdreq_op,
  input  logic [ADDR_W-1:0]              cdreq_addr,
  input  logic [BLK_W-1:0]               cdreq_data,
  output logic                           cdreq_ready,
  output logic                           cursp_valid,
  output core_rsp_t                      cursp_rsp,
  output logic [BLK_W-1:0]               cursp_data,
  input  logic                           cursp_ready,

  // memory request / response
  output logic                           sdreq_valid,
  output mem_op_t                        sdreq_op,
  output logic [ADDR_W-1:0]              sdreq_addr,
  output logic [BLK_W-1:0]               sdreq_data,
  input  logic                           sdreq_ready,
  input  logic                           sursp_valid,
  input  logic [BLK_W-1:0]               sursp_data,
  output logic                           sursp_ready,

  // lookup results
  input  logic                           lookup_hit,
  input  logic [WAY_W-1:0]               hit_way,
  input  logic                           free_valid,
  input  logic [WAY_W-1:0]               free_way,
  input  logic [WAY_W-1:0]               victim_way,
  input  blk_state_t [NUM_WAYS-1:0]      way_state,
  input  logic [NUM_WAYS-1:0][TAG_W-1:0] way_tag,
  input  logic [BLK_W-1:0]               rd_data,

  // array and replacement control
  output logic [IDX_W-1:0]               set_idx,
  output logic [TAG_W-1:0]               lookup_tag,
  output logic                           tag_wr_en,
  output logic [WAY_W-1:0]               tag_wr_way,
  output blk_state_t                     tag_wr_state,
  output logic                           data_wr_en,
  output logic [WAY_W-1:0]               data_wr_way,
  output logic [BLK_W-1:0]               data_wr_data,
  output logic [WAY_W-1:0]               rd_way,
  output logic                           touch_en,
  output logic [WAY_W-1:0]               touch_way
);

  ctrl_phase_t       phase_q;
  ctrl_phase_t       phase_d;
  core_op_t          req_op_q;
  logic [ADDR_W-1:0] req_addr_q;
  logic [BLK_W-1:0]  req_data_q;
  logic [WAY_W-1:0]  tgt_way_q;
  logic              rsp_err_q;

  logic              req_xfer;
  logic              rsp_xfer;
  logic              mreq_xfer;
  logic              mrsp_xfer;
  logic              fill_xfer;
  logic [WAY_W-1:0]  lookup_way;
  logic              victim_dirty;

  assign req_xfer  = cdreq_valid && cdreq_ready;
  assign rsp_xfer  = cursp_valid && cursp_ready;
  assign mreq_xfer = sdreq_valid && sdreq_ready;
  assign mrsp_xfer = sursp_valid && sursp_ready;
  assign fill_xfer = mrsp_xfer && (phase_q == FILL_WAIT);

  // ------------------------------
  // request buffer
  // ------------------------------
  always_ff @(posedge clk) begin
    if (req_xfer) begin
      req_op_q   <= cdreq_op;
      req_addr_q <= cdreq_addr;
      req_data_q <= cdreq_data;
    end
  end

  assign set_idx    = req_addr_q[IDX_W-1:0];
  assign lookup_tag = req_addr_q[ADDR_W-1:IDX_W];

  // target way: hit, else lowest free, else plru victim
  assign lookup_way   = lookup_hit ? hit_way : (free_valid ? free_way : victim_way);
  assign victim_dirty = !free_valid && (way_state[victim_way] == MODIFIED);

  // ------------------------------
  // phase controller
  // ------------------------------
  always_comb begin
    phase_d = phase_q;
    case (phase_q)
      IDLE: begin
        if (req_xfer) phase_d = LOOKUP;
      end
      LOOKUP: begin
        // WB miss answers ERROR without touching memory
        if (lookup_hit || (req_op_q == CORE_WB)) begin
          phase_d = SEND_RSP;
        end else if (victim_dirty) begin
          phase_d = EVICT_REQ;
        end else begin
          phase_d = FILL_REQ;
        end
      end
      EVICT_REQ: begin
        if (mreq_xfer) phase_d = EVICT_WAIT;
      end
      EVICT_WAIT: begin
        if (mrsp_xfer) phase_d = FILL_REQ;
      end
      FILL_REQ: begin
        if (mreq_xfer) phase_d = FILL_WAIT;
      end
      FILL_WAIT: begin
        if (mrsp_xfer) phase_d = SEND_RSP;
      end
      SEND_RSP: begin
        if (rsp_xfer) phase_d = IDLE;
      end
      default: phase_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_q   <= IDLE;
      tgt_way_q <= '0;
      rsp_err_q <= 1'b0;
    end else begin
      phase_q <= phase_d;
      if (phase_q == LOOKUP) begin
        tgt_way_q <= lookup_way;
        rsp_err_q <= (req_op_q == CORE_WB) && !lookup_hit;
      end
    end
  end

  // ------------------------------
  // channel payloads
  // ------------------------------
  assign cdreq_ready = (phase_q == IDLE);
  assign sursp_ready = (phase_q == EVICT_WAIT) || (phase_q == FILL_WAIT);

  assign cursp_valid = (phase_q == SEND_RSP);
  assign cursp_rsp   = rsp_err_q ? RSP_ERROR : RSP_OKAY;
  assign cursp_data  = rd_data;

  // eviction carries the victim's own address and data
  assign sdreq_valid = (phase_q == EVICT_REQ) || (phase_q == FILL_REQ);
  assign sdreq_op    = (phase_q == EVICT_REQ) ? MEM_WB :
                       (req_op_q == CORE_RFO) ? MEM_RFO : MEM_RD;
  assign sdreq_addr  = (phase_q == EVICT_REQ) ? {way_tag[tgt_way_q], set_idx} : req_addr_q;
  assign sdreq_data  = (phase_q == EVICT_REQ) ? rd_data : '0;

  assign rd_way = tgt_way_q;

  // ------------------------------
  // array and plru updates
  // ------------------------------
  // fill installs the block, RFO and WB hits go MODIFIED on the response
  assign tag_wr_en    = fill_xfer || (rsp_xfer && !rsp_err_q && (req_op_q != CORE_RD));
  assign tag_wr_way   = tgt_way_q;
  assign tag_wr_state = (req_op_q == CORE_RD) ? EXCLUSIVE : MODIFIED;

  assign data_wr_en   = fill_xfer || (rsp_xfer && !rsp_err_q && (req_op_q == CORE_WB));
  assign data_wr_way  = tgt_way_q;
  assign data_wr_data = (phase_q == FILL_WAIT) ? sursp_data : req_data_q;

  assign touch_en  = rsp_xfer && !rsp_err_q;
  assign touch_way = tgt_way_q;

endmodule

//--- hw/cache_top.sv
`timescale 1ns/100ps

module cache_top import cache_proto_pkg::*; import cache_state_pkg::*; #(
  parameter int ADDR_W   = 6,
  parameter int BLK_W    = 64,
  parameter int NUM_SETS = 4
) (
  input  logic              clk,
  input  logic              rst_n,

  input  logic              cdreq_valid,
  input  core_op_t          cdreq_op,
  input  logic [ADDR_W-1:0] cdreq_addr,
  input  logic [BLK_W-1:0]  cdreq_data,
  output logic              cdreq_ready,

  output logic              cursp_valid,
  output core_rsp_t         cursp_rsp,
  output logic [BLK_W-1:0]  cursp_data,
  input  logic              cursp_ready,

  output logic              sdreq_valid,
  output mem_op_t           sdreq_op,
  output logic [ADDR_W-1:0] sdreq_addr,
  output logic [BLK_W-1:0]  sdreq_data,
  input  logic              sdreq_ready,

  input  logic              sursp_valid,
  input  logic [BLK_W-1:0]  sursp_data,
  output logic              sursp_ready
);

  localparam int IDX_W = $clog2(NUM_SETS);
  localparam int TAG_W = ADDR_W - IDX_W;

  // ------------------------------
  // lookup and array wires
  // ------------------------------
  logic [IDX_W-1:0]                set_idx;
  logic [TAG_W-1:0]                lookup_tag;
  logic                            lookup_hit;
  logic [WAY_W-1:0]                hit_way;
  logic                            free_valid;
  logic [WAY_W-1:0]                free_way;
  logic [WAY_W-1:0]                victim_way;
  blk_state_t [NUM_WAYS-1:0]       way_state;
  logic [NUM_WAYS-1:0][TAG_W-1:0]  way_tag;

  logic                            tag_wr_en;
  logic [WAY_W-1:0]                tag_wr_way;
  blk_state_t                      tag_wr_state;

  logic                            data_wr_en;
  logic [WAY_W-1:0]                data_wr_way;
  logic [BLK_W-1:0]                data_wr_data;
  logic [WAY_W-1:0]                rd_way;
  logic [BLK_W-1:0]                rd_data;

  logic                            touch_en;
  logic [WAY_W-1:0]                touch_way;

  cache_ctrl #(
    .ADDR_W   (ADDR_W),
    .BLK_W    (BLK_W),
    .NUM_SETS (NUM_SETS)
  ) u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .cdreq_valid  (cdreq_valid),
    .cdreq_op     (cdreq_op),
    .cdreq_addr   (cdreq_addr),
    .cdreq_data   (cdreq_data),
    .cdreq_ready  (cdreq_ready),
    .cursp_valid  (cursp_valid),
    .cursp_rsp    (cursp_rsp),
    .cursp_data   (cursp_data),
    .cursp_ready  (cursp_ready),
    .sdreq_valid  (sdreq_valid),
    .sdreq_op     (sdreq_op),
    .sdreq_addr   (sdreq_addr),
    .sdreq_data   (sdreq_data),
    .sdreq_ready  (sdreq_ready),
    .sursp_valid  (sursp_valid),
    .sursp_data   (sursp_data),
    .sursp_ready  (sursp_ready),
    .lookup_hit   (lookup_hit),
    .hit_way      (hit_way),
    .free_valid   (free_valid),
    .free_way     (free_way),
    .victim_way   (victim_way),
    .way_state    (way_state),
    .way_tag      (way_tag),
    .rd_data      (rd_data),
    .set_idx      (set_idx),
    .lookup_tag   (lookup_tag),
    .tag_wr_en    (tag_wr_en),
    .tag_wr_way   (tag_wr_way),
    .tag_wr_state (tag_wr_state),
    .data_wr_en   (data_wr_en),
    .data_wr_way  (data_wr_way),
    .data_wr_data (data_wr_data),
    .rd_way       (rd_way),
    .touch_en     (touch_en),
    .touch_way    (touch_way)
  );

  tag_array #(
    .ADDR_W   (ADDR_W),
    .NUM_SETS (NUM_SETS)
  ) u_tag (
    .clk          (clk),
    .rst_n        (rst_n),
    .set_idx      (set_idx),
    .lookup_tag   (lookup_tag),
    .tag_wr_en    (tag_wr_en),
    .tag_wr_way   (tag_wr_way),
    .tag_wr_state (tag_wr_state),
    .lookup_hit   (lookup_hit),
    .hit_way      (hit_way),
    .free_valid   (free_valid),
    .free_way     (free_way),
    .way_state    (way_state),
    .way_tag      (way_tag)
  );

  data_array #(
    .BLK_W    (BLK_W),
    .NUM_SETS (NUM_SETS)
  ) u_data (
    .clk          (clk),
    .set_idx      (set_idx),
    .rd_way       (rd_way),
    .data_wr_en   (data_wr_en),
    .data_wr_way  (data_wr_way),
    .data_wr_data (data_wr_data),
    .rd_data      (rd_data)
  );

  plru_repl #(
    .NUM_SETS (NUM_SETS)
  ) u_plru (
    .clk        (clk),
    .rst_n      (rst_n),
    .set_idx    (set_idx),
    .touch_en   (touch_en),
    .touch_way  (touch_way),
    .victim_way (victim_way)
  );

endmodule

//--- hw/plru_repl.sv
`timescale 1ns/100ps

module plru_repl import cache_proto_pkg::*; #(
  parameter int NUM_SETS = 4,
  localparam int IDX_W   = $clog2(NUM_SETS)
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [IDX_W-1:0] set_idx,
  input  logic             touch_en,
  input  logic [WAY_W-1:0] touch_way,
  output logic [WAY_W-1:0] victim_way
);

  // tree bits per set
  // bit 2 picks the half, bit 1 covers ways 0/1, bit 0 covers ways 2/3
  logic [2:0] tree_q [NUM_SETS];
  logic [2:0] tree;

  assign tree = tree_q[set_idx];

  // ------------------------------
  // victim selection
  // ------------------------------
  assign victim_way[1] = tree[2];
  assign victim_way[0] = tree[2] ? tree[0] : tree[1];

  // ------------------------------
  // touch update
  // ------------------------------
  // point every node on the path away from the touched way
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        tree_q[s] <= 3'b000;
      end
    end else if (touch_en) begin
      tree_q[set_idx][2] <= ~touch_way[1];
      if (touch_way[1]) begin
        tree_q[set_idx][0] <= ~touch_way[0];
      end else begin
        tree_q[set_idx][1] <= ~touch_way[0];
      end
    end
  end

endmodule

//--- verif/cache_chk.sv
`timescale 1ns/100ps

module cache_chk import cache_proto_pkg::*; #(
  parameter int ADDR_W = 6,
  parameter int BLK_W  = 64
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cdreq_valid,
  input  logic              cdreq_ready,
  input  logic              cursp_valid,
  input  logic              cursp_ready,
  input  core_rsp_t         cursp_rsp,
  input  logic [BLK_W-1:0]  cursp_data,
  input  logic              sdreq_valid,
  input  logic              sdreq_ready,
  input  mem_op_t           sdreq_op,
  input  logic [ADDR_W-1:0] sdreq_addr,
  input  logic [BLK_W-1:0]  sdreq_data,
  input  logic              sursp_valid,
  input  logic              sursp_ready
);

  int   fail_count = 0;
  logic mem_pending;
  logic req_open;

  // a memory request has gone out and its response has not come back yet
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_pending <= 1'b0;
    end else if (sdreq_valid && sdreq_ready) begin
      mem_pending <= 1'b1;
    end else if (sursp_valid && sursp_ready) begin
      mem_pending <= 1'b0;
    end
  end

  // a core request has been taken and its response has not gone back yet
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_open <= 1'b0;
    end else if (cdreq_valid && cdreq_ready) begin
      req_open <= 1'b1;
    end else if (cursp_valid && cursp_ready) begin
      req_open <= 1'b0;
    end
  end

  // ------------------------------
  // handshake properties
  // ------------------------------
  rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    cursp_valid && !cursp_ready |=>
      cursp_valid && $stable(cursp_rsp) && $stable(cursp_data))
    else begin
      $error("core response dropped or changed while stalled");
      fail_count++;
    end

  mreq_hold: assert property (@(posedge clk) disable iff (!rst_n)
    sdreq_valid && !sdreq_ready |=>
      sdreq_valid && $stable(sdreq_op) && $stable(sdreq_addr) && $stable(sdreq_data))
    else begin
      $error("memory request dropped or changed while stalled");
      fail_count++;
    end

  no_accept_with_rsp: assert property (@(posedge clk) disable iff (!rst_n)
    cdreq_ready |-> !cursp_valid && !req_open)
    else begin
      $error("new request accepted while a response is pending");
      fail_count++;
    end

  mrsp_only_pending: assert property (@(posedge clk) disable iff (!rst_n)
    sursp_ready |-> mem_pending)
    else begin
      $error("memory response taken with no memory request outstanding");
      fail_count++;
    end

endmodule

//--- verif/tb_checker.sv
`timescale 1ns/100ps

module tb_checker import cache_proto_pkg::*; import cache_state_pkg::*; #(
  parameter int ADDR_W   = 6,
  parameter int BLK_W    = 64,
  parameter int NUM_SETS = 4,
  localparam int IDX_W   = $clog2(NUM_SETS),
  localparam int TAG_W   = ADDR_W - IDX_W
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cdreq_valid,
  input  core_op_t          cdreq_op,
  input  logic [ADDR_W-1:0] cdreq_addr,
  input  logic [BLK_W-1:0]  cdreq_data,
  input  logic              cdreq_ready,
  input  logic              cursp_valid,
  input  core_rsp_t         cursp_rsp,
  input  logic [BLK_W-1:0]  cursp_data,
  input  logic              cursp_ready,
  input  logic              sdreq_valid,
  input  mem_op_t           sdreq_op,
  input  logic [ADDR_W-1:0] sdreq_addr,
  input  logic [BLK_W-1:0]  sdreq_data,
  input  logic              sdreq_ready,
  output int                value_errs,
  output int                order_errs,
  output int                rsp_count
);

  // ------------------------------
  // model state
  // ------------------------------
  blk_state_t        m_state [NUM_SETS][NUM_WAYS];
  logic [TAG_W-1:0]  m_tag   [NUM_SETS][NUM_WAYS];
  logic [2:0]        m_tree  [NUM_SETS];
  // last written value of every block
  logic [BLK_W-1:0]  shadow  [2**ADDR_W];

  // memory requests still expected for the current core request
  mem_op_t           q_op   [$];
  logic [ADDR_W-1:0] q_addr [$];
  logic [BLK_W-1:0]  q_data [$];

  logic              busy;
  logic              seen_valid;
  logic              fast_rsp;
  logic              check_data;
  core_rsp_t         exp_rsp;
  logic [BLK_W-1:0]  exp_data;
  string             rsp_name;
  int                cyc;
  int                accept_cyc;

  function automatic logic [BLK_W-1:0] initial_value(input logic [ADDR_W-1:0] addr);
    return {4{2'b10, addr, ~addr, 2'b01}};
  endfunction

  // tree bit 2 picks the half, bits 1 and 0 pick inside the low and high half
  function automatic logic [WAY_W-1:0] pick_victim(input logic [2:0] t);
    return t[2] ? {1'b1, t[0]} : {1'b0, t[1]};
  endfunction

  // every node on the path turns away from the used way
  function automatic logic [2:0] touch_tree(input logic [2:0] t, input logic [WAY_W-1:0] w);
    logic [2:0] n;
    n    = t;
    n[2] = ~w[1];
    if (w[1]) begin
      n[0] = ~w[0];
    end else begin
      n[1] = ~w[0];
    end
    return n;
  endfunction

  task automatic value_mismatch(input string name, input logic [BLK_W-1:0] exp_val,
                                input logic [BLK_W-1:0] act_val);
    $display("FAIL %s: expected %h, actual %h", name, exp_val, act_val);
    value_errs++;
  endtask

  task automatic protocol_error(input string what);
    $display("ERROR at cycle %0d: %s", cyc, what);
    order_errs++;
  endtask

  // ------------------------------
  // reference model
  // ------------------------------
  task automatic model_request(input core_op_t op, input logic [ADDR_W-1:0] addr,
                               input logic [BLK_W-1:0] data);
    logic [IDX_W-1:0]  idx;
    logic [TAG_W-1:0]  tag;
    logic              hit;
    logic              free;
    logic [WAY_W-1:0]  way;
    logic [ADDR_W-1:0] vaddr;
    idx  = addr[IDX_W-1:0];
    tag  = addr[ADDR_W-1:IDX_W];
    hit  = 1'b0;
    free = 1'b0;
    way  = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (!hit && m_state[idx][w] != INVALID && m_tag[idx][w] == tag) begin
        hit = 1'b1;
        way = WAY_W'(w);
      end
    end
    busy       = 1'b1;
    seen_valid = 1'b0;
    accept_cyc = cyc;
    fast_rsp   = hit || (op == CORE_WB);
    exp_rsp    = (op == CORE_WB && !hit) ? RSP_ERROR : RSP_OKAY;
    exp_data   = shadow[addr];
    check_data = (op != CORE_WB);
    rsp_name   = $sformatf("%s response addr %h", op.name(), addr);
    if (hit) begin
      if (op != CORE_RD) begin
        m_state[idx][way] = MODIFIED;
      end
      if (op == CORE_WB) begin
        shadow[addr] = data;
      end
    end else if (op != CORE_WB) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (!free && m_state[idx][w] == INVALID) begin
          free = 1'b1;
          way  = WAY_W'(w);
        end
      end
      if (!free) begin
        way = pick_victim(m_tree[idx]);
        // dirty victim goes back to memory before the fill
        if (m_state[idx][way] == MODIFIED) begin
          vaddr = {m_tag[idx][way], idx};
          q_op.push_back(MEM_WB);
          q_addr.push_back(vaddr);
          q_data.push_back(shadow[vaddr]);
        end
      end
      q_op.push_back((op == CORE_RFO) ? MEM_RFO : MEM_RD);
      q_addr.push_back(addr);
      q_data.push_back({BLK_W{1'b0}});
      m_tag[idx][way]   = tag;
      m_state[idx][way] = (op == CORE_RD) ? EXCLUSIVE : MODIFIED;
    end
    if (exp_rsp == RSP_OKAY) begin
      m_tree[idx] = touch_tree(m_tree[idx], way);
    end
  endtask

  task automatic check_mem_req();
    mem_op_t           op;
    logic [ADDR_W-1:0] addr;
    logic [BLK_W-1:0]  data;
    if (q_op.size() == 0) begin
      protocol_error($sformatf("memory request to %h with none expected", sdreq_addr));
    end else begin
      op   = q_op.pop_front();
      addr = q_addr.pop_front();
      data = q_data.pop_front();
      if (sdreq_op != op) begin
        value_mismatch("memory request op", BLK_W'(op), BLK_W'(sdreq_op));
      end
      if (sdreq_addr != addr) begin
        value_mismatch("memory request addr", BLK_W'(addr), BLK_W'(sdreq_addr));
      end
      if (op == MEM_WB && sdreq_data != data) begin
        value_mismatch("memory writeback data", data, sdreq_data);
      end
    end
  endtask

  task automatic check_response();
    if (!busy) begin
      protocol_error("core response with no request outstanding");
    end else begin
      if (cursp_rsp != exp_rsp) begin
        value_mismatch({rsp_name, " code"}, BLK_W'(exp_rsp), BLK_W'(cursp_rsp));
      end
      if (check_data && cursp_data != exp_data) begin
        value_mismatch({rsp_name, " data"}, exp_data, cursp_data);
      end
      if (q_op.size() != 0) begin
        protocol_error($sformatf("%s came before %0d memory requests", rsp_name, q_op.size()));
        q_op.delete();
        q_addr.delete();
        q_data.delete();
      end
      busy = 1'b0;
      rsp_count++;
    end
  endtask

  // ------------------------------
  // port monitor
  // ------------------------------
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        m_tree[s] = 3'b000;
        for (int w = 0; w < NUM_WAYS; w++) begin
          m_state[s][w] = INVALID;
          m_tag[s][w]   = '0;
        end
      end
      for (int a = 0; a < 2**ADDR_W; a++) begin
        shadow[a] = initial_value(ADDR_W'(a));
      end
      q_op.delete();
      q_addr.delete();
      q_data.delete();
      busy       = 1'b0;
      seen_valid = 1'b0;
      value_errs = 0;
      order_errs = 0;
      rsp_count  = 0;
      cyc        = 0;
    end else begin
      cyc++;
      // hits and WB errors answer two edges after the accept
      if (busy && cursp_valid && !seen_valid) begin
        seen_valid = 1'b1;
        if (fast_rsp && cyc != accept_cyc + 2) begin
          protocol_error($sformatf("%s took %0d cycles instead of 2", rsp_name,
                                   cyc - accept_cyc));
        end
      end
      if (sdreq_valid && sdreq_ready) begin
        check_mem_req();
      end
      if (cursp_valid && cursp_ready) begin
        check_response();
      end
      if (cdreq_valid && cdreq_ready) begin
        model_request(cdreq_op, cdreq_addr, cdreq_data);
      end
    end
  end

endmodule

//--- verif/tb_top.sv
`timescale 1ns/100ps

module tb_top import cache_proto_pkg::*; ();

  localparam int ADDR_W   = 6;
  localparam int BLK_W    = 64;
  localparam int NUM_SETS = 4;
  localparam int NUM_REQ  = 300;
  localparam int MAX_CYC  = NUM_REQ * 60;

  logic              clk;
  logic              rst_n;
  logic              cdreq_valid;
  core_op_t          cdreq_op;
  logic [ADDR_W-1:0] cdreq_addr;
  logic [BLK_W-1:0]  cdreq_data;
  logic              cdreq_ready;
  logic              cursp_valid;
  core_rsp_t         cursp_rsp;
  logic [BLK_W-1:0]  cursp_data;
  logic              cursp_ready = 1'b0;
  logic              sdreq_valid;
  mem_op_t           sdreq_op;
  logic [ADDR_W-1:0] sdreq_addr;
  logic [BLK_W-1:0]  sdreq_data;
  logic              sdreq_ready;
  logic              sursp_valid;
  logic [BLK_W-1:0]  sursp_data;
  logic              sursp_ready;

  int                value_errs;
  int                order_errs;
  int                rsp_count;
  int                cyc = 0;
  logic [31:0]       lfsr = 32'd7;
  logic [BLK_W-1:0]  mem [2**ADDR_W];

  // galois LFSR stepped once per bit taken
  function automatic logic [BLK_W-1:0] rand_bits(input int n);
    logic [BLK_W-1:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[BLK_W-2:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic logic [BLK_W-1:0] init_pattern(input logic [ADDR_W-1:0] addr);
    return {4{2'b10, addr, ~addr, 2'b01}};
  endfunction

  task automatic print_counts();
    $display("responses %0d of %0d, value errors %0d, protocol errors %0d, assertion fails %0d",
             rsp_count, NUM_REQ, value_errs, order_errs, uut.u_ctrl.u_chk.fail_count);
  endtask

  initial clk = 1'b0;
  always #2 clk = ~clk;

  cache_top #(
    .ADDR_W   (ADDR_W),
    .BLK_W    (BLK_W),
    .NUM_SETS (NUM_SETS)
  ) uut (.*);

  tb_checker #(
    .ADDR_W   (ADDR_W),
    .BLK_W    (BLK_W),
    .NUM_SETS (NUM_SETS)
  ) u_checker (.*);

  bind cache_ctrl cache_chk #(
    .ADDR_W (ADDR_W),
    .BLK_W  (BLK_W)
  ) u_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .cdreq_valid (cdreq_valid),
    .cdreq_ready (cdreq_ready),
    .cursp_valid (cursp_valid),
    .cursp_ready (cursp_ready),
    .cursp_rsp   (cursp_rsp),
    .cursp_data  (cursp_data),
    .sdreq_valid (sdreq_valid),
    .sdreq_ready (sdreq_ready),
    .sdreq_op    (sdreq_op),
    .sdreq_addr  (sdreq_addr),
    .sdreq_data  (sdreq_data),
    .sursp_valid (sursp_valid),
    .sursp_ready (sursp_ready)
  );

  // ------------------------------
  // core request stimulus
  // ------------------------------
  initial begin
    logic [BLK_W-1:0]  r;
    core_op_t          op;
    logic [ADDR_W-1:0] addr;
    rst_n       = 1'b0;
    cdreq_valid = 1'b0;
    cdreq_op    = CORE_RD;
    cdreq_addr  = '0;
    cdreq_data  = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < NUM_REQ; i++) begin
      r  = rand_bits(6);
      op = (r[1:0] == 2'd3) ? CORE_RD : core_op_t'(r[1:0]);
      // 16 blocks with six each in sets 0 and 1 so those sets overflow
      addr        = {r[5:2], r[5] & r[3], r[2]};
      cdreq_valid = 1'b1;
      cdreq_op    = op;
      cdreq_addr  = addr;
      cdreq_data  = (op == CORE_WB) ? rand_bits(64) : '0;
      while (!cdreq_ready) begin
        @(negedge clk);
      end
      @(negedge clk);
    end
    cdreq_valid = 1'b0;
    wait (rsp_count == NUM_REQ);
    @(negedge clk);
    print_counts();
    if (value_errs == 0 && order_errs == 0 && uut.u_ctrl.u_chk.fail_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // random core back-pressure
  always @(negedge clk) begin
    if (rst_n) begin
      cursp_ready = |rand_bits(2);
    end
  end

  // ------------------------------
  // memory side
  // ------------------------------
  initial begin
    mem_op_t           op;
    logic [ADDR_W-1:0] addr;
    logic [BLK_W-1:0]  r;
    sdreq_ready = 1'b0;
    sursp_valid = 1'b0;
    sursp_data  = '0;
    for (int a = 0; a < 2**ADDR_W; a++) begin
      mem[a] = init_pattern(ADDR_W'(a));
    end
    wait (rst_n);
    forever begin
      @(negedge clk);
      sdreq_ready = |rand_bits(2);
      if (sdreq_valid && sdreq_ready) begin
        // transfer happens on the coming rising edge
        op   = sdreq_op;
        addr = sdreq_addr;
        if (op == MEM_WB) begin
          mem[addr] = sdreq_data;
        end
        @(negedge clk);
        sdreq_ready = 1'b0;
        r = rand_bits(3);
        repeat (r[2:0]) @(negedge clk);
        sursp_valid = 1'b1;
        sursp_data  = (op == MEM_WB) ? '0 : mem[addr];
        while (!sursp_ready) begin
          @(negedge clk);
        end
        @(negedge clk);
        sursp_valid = 1'b0;
      end
    end
  end

  // run limit
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc > MAX_CYC) begin
      $display("timeout: run stopped after %0d cycles without all responses", cyc);
      print_counts();
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

endmodule

//--- verilog.f
common/cache_proto_pkg.sv
common/cache_state_pkg.sv
hw/cache_array/tag_array.sv
hw/cache_array/data_array.sv
hw/plru_repl.sv
hw/cache_ctrl.sv
hw/cache_top.sv
verif/cache_chk.sv
verif/tb_checker.sv
verif/tb_top.sv
